/* dv/csr_tb.sv */
module csr_tb;

  localparam logic [1:0] K_CSR  = 2'd0;
  localparam logic [1:0] K_RND  = 2'd1; // operand drawn at run time.
  localparam logic [1:0] K_MEM  = 2'd2;
  localparam logic [1:0] K_BOTH = 2'd3; // illegal csr plus memory access.
  localparam int TIMEOUT = 20;

  typedef struct packed {
    logic [1:0]                         kind;
    csr_pkg::csr_op_e                   op;
    logic [csr_pkg::CSR_ADDR_WIDTH-1:0] addr;
    logic [31:0]                        operand;
    logic [31:0]                        vaddr;
    logic                               store;
  } entry_t;

  logic              clk_i;
  logic              rst_i;
  logic              csr_valid_i;
  csr_pkg::csr_req_t csr_req_i;
  logic              mem_valid_i;
  mmu_pkg::mem_req_t mem_req_i;
  logic              rd_valid_o;
  logic [31:0]       rd_data_o;
  logic              mem_ok_o;
  logic              trap_o;
  logic [31:0]       trap_pc_o;
  logic [31:0]       satp_o;

  entry_t                        tbl[$];
  logic [31:0]                   m_satp, m_mtvec, m_mepc, m_mcause, m_mtval, m_sel;
  logic [mmu_pkg::PPN_COUNT-1:0] m_present;
  integer                        seed = 14270;
  int                            errors = 0;
  int                            checks = 0;

  csr_top u_dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .csr_valid_i (csr_valid_i),
    .csr_req_i   (csr_req_i),
    .mem_valid_i (mem_valid_i),
    .mem_req_i   (mem_req_i),
    .rd_valid_o  (rd_valid_o),
    .rd_data_o   (rd_data_o),
    .mem_ok_o    (mem_ok_o),
    .trap_o      (trap_o),
    .trap_pc_o   (trap_pc_o),
    .satp_o      (satp_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic entry_t ent(input logic [1:0] kind, input csr_pkg::csr_op_e op,
                                 input logic [11:0] addr, input logic [31:0] operand,
                                 input logic [31:0] vaddr, input logic store);
    entry_t e;
    e.kind    = kind;
    e.op      = op;
    e.addr    = addr;
    e.operand = operand;
    e.vaddr   = vaddr;
    e.store   = store;
    return e;
  endfunction

  function automatic logic is_mapped(input logic [11:0] addr);
    case (addr)
      csr_pkg::CSR_SATP, csr_pkg::CSR_MTVEC, csr_pkg::CSR_MEPC, csr_pkg::CSR_MCAUSE,
      csr_pkg::CSR_MTVAL, csr_pkg::CSR_PPN_SEL, csr_pkg::CSR_PPN_FLAG: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] model_read(input logic [11:0] addr);
    case (addr)
      csr_pkg::CSR_SATP:    return m_satp;
      csr_pkg::CSR_MTVEC:   return m_mtvec;
      csr_pkg::CSR_MEPC:    return m_mepc;
      csr_pkg::CSR_MCAUSE:  return m_mcause;
      csr_pkg::CSR_MTVAL:   return m_mtval;
      csr_pkg::CSR_PPN_SEL: return m_sel;
      default:              return 32'h0; // flag csr is write only.
    endcase
  endfunction

  function automatic void model_write(input logic [11:0] addr, input logic [31:0] v);
    case (addr)
      csr_pkg::CSR_SATP:     m_satp   = v;
      csr_pkg::CSR_MTVEC:    m_mtvec  = v;
      csr_pkg::CSR_MEPC:     m_mepc   = v;
      csr_pkg::CSR_MCAUSE:   m_mcause = v;
      csr_pkg::CSR_MTVAL:    m_mtval  = v;
      csr_pkg::CSR_PPN_SEL:  m_sel    = v;
      csr_pkg::CSR_PPN_FLAG: m_present[m_sel[mmu_pkg::PPN_WIDTH-1:0]] = v[0];
      default: ;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  initial begin
    entry_t            e;
    csr_pkg::csr_req_t req;
    mmu_pkg::mem_req_t mreq;
    logic              csr_act, mem_act, fault, illegal, exp_rd, exp_ok, exp_trap;
    logic [7:0]        vpn;
    logic [31:0]       pc, old, nxt, exp_pc;
    int                waited;
    int                errs_before;

    rst_i       = 1'b0;
    csr_valid_i = 1'b0;
    csr_req_i   = '0;
    mem_valid_i = 1'b0;
    mem_req_i   = '0;
    {m_satp, m_mtvec, m_mepc, m_mcause, m_mtval, m_sel} = '0;
    m_present = '0;

    tbl.push_back(ent(K_CSR, csr_pkg::CSR_OP_SET, csr_pkg::CSR_SATP, 0, 0, 1'b0));
    tbl.push_back(ent(K_CSR, csr_pkg::CSR_OP_SET, csr_pkg::CSR_MTVEC, 0, 0, 1'b0));
    tbl.push_back(ent(K_CSR, csr_pkg::CSR_OP_SET, csr_pkg::CSR_MCAUSE, 0, 0, 1'b0));
    tbl.push_back(ent(K_RND, csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_MTVEC, 0, 0, 1'b0));
    tbl.push_back(ent(K_CSR, csr_pkg::CSR_OP_SET, csr_pkg::CSR_MTVEC, 0, 0, 1'b0));
    tbl.push_back(ent(K_RND, csr_pkg::CSR_OP_SET, csr_pkg::CSR_MTVEC, 0, 0, 1'b0));
    tbl.push_back(ent(K_CSR, csr_pkg::CSR_OP_SET, csr_pkg::CSR_MTVEC, 0, 0, 1'b0));
    tbl.push_back(ent(K_RND, csr_pkg::CSR_OP_CLEAR, csr_pkg::CSR_MTVEC, 0, 0, 1'b0));
    tbl.push_back(ent(K_CSR, csr_pkg::CSR_OP_SET, csr_pkg::CSR_MTVEC, 0, 0, 1'b0));
    tbl.push_back(ent(K_CSR, csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_PPN_SEL, 5, 0, 1'b0));
    tbl.push_back(ent(K_CSR, csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_PPN_FLAG, 1, 0, 1'b0));
    tbl.push_back(ent(K_CSR, csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_PPN_SEL, 9, 0, 1'b0));
    tbl.push_back(ent(K_CSR, csr_pkg::CSR_OP_SET, csr_pkg::CSR_PPN_FLAG, 1, 0, 1'b0));
    tbl.push_back(ent(K_MEM, csr_pkg::CSR_OP_SET, 12'h0, 0, 32'h0000_7123, 1'b0)); // bare.
    tbl.push_back(ent(K_CSR, csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_MTVEC, 32'h100, 0, 1'b0));
    tbl.push_back(ent(K_CSR, csr_pkg::CSR_OP_SET, csr_pkg::CSR_SATP, 32'h8000_0000, 0, 1'b0));
    tbl.push_back(ent(K_MEM, csr_pkg::CSR_OP_SET, 12'h0, 0, 32'h0000_5010, 1'b0));
    tbl.push_back(ent(K_MEM, csr_pkg::CSR_OP_SET, 12'h0, 0, 32'h0000_9ffc, 1'b1));
    tbl.push_back(ent(K_MEM, csr_pkg::CSR_OP_SET, 12'h0, 0, 32'h0000_7004, 1'b0));
    tbl.push_back(ent(K_CSR, csr_pkg::CSR_OP_SET, csr_pkg::CSR_MCAUSE, 0, 0, 1'b0));
    tbl.push_back(ent(K_CSR, csr_pkg::CSR_OP_SET, csr_pkg::CSR_MTVAL, 0, 0, 1'b0));
    tbl.push_back(ent(K_CSR, csr_pkg::CSR_OP_SET, csr_pkg::CSR_MEPC, 0, 0, 1'b0));
    tbl.push_back(ent(K_MEM, csr_pkg::CSR_OP_SET, 12'h0, 0, 32'h0004_2008, 1'b1));
    tbl.push_back(ent(K_CSR, csr_pkg::CSR_OP_SET, csr_pkg::CSR_MCAUSE, 0, 0, 1'b0));
    tbl.push_back(ent(K_CSR, csr_pkg::CSR_OP_WRITE, 12'h7FF, 32'h55, 0, 1'b0)); // unmapped.
    tbl.push_back(ent(K_CSR, csr_pkg::CSR_OP_SET, csr_pkg::CSR_MCAUSE, 0, 0, 1'b0));
    tbl.push_back(ent(K_CSR, csr_pkg::CSR_OP_SET, csr_pkg::CSR_MTVAL, 0, 0, 1'b0));
    tbl.push_back(ent(K_CSR, csr_pkg::CSR_OP_SET, csr_pkg::CSR_MEPC, 0, 0, 1'b0));
    tbl.push_back(ent(K_BOTH, csr_pkg::CSR_OP_WRITE, 12'h123, 1, 32'h0000_6000, 1'b0));
    tbl.push_back(ent(K_CSR, csr_pkg::CSR_OP_SET, csr_pkg::CSR_MCAUSE, 0, 0, 1'b0));
    tbl.push_back(ent(K_CSR, csr_pkg::CSR_OP_SET, csr_pkg::CSR_MTVAL, 0, 0, 1'b0));

    repeat (5) @(posedge clk_i);
    rst_i <= 1'b1;

    for (int i = 0; i < tbl.size(); i++) begin
      e = tbl[i];
      if (e.kind == K_RND) begin
        e.operand = $random(seed);
      end
      pc       = 32'h0000_1000 + 32'(i) * 32'd4;
      vpn      = e.vaddr[mmu_pkg::PAGE_SHIFT +: mmu_pkg::PPN_WIDTH];
      csr_act  = (e.kind != K_MEM);
      mem_act  = (e.kind == K_MEM) || (e.kind == K_BOTH);
      fault    = mem_act && m_satp[mmu_pkg::SATP_MODE_BIT] && !m_present[vpn];
      illegal  = csr_act && !is_mapped(e.addr);
      exp_trap = fault || illegal;
      exp_rd   = csr_act && !illegal;
      exp_ok   = mem_act && !exp_trap;
      exp_pc   = m_mtvec;
      old      = model_read(e.addr);
      case (e.op)
        csr_pkg::CSR_OP_SET:   nxt = old | e.operand;
        csr_pkg::CSR_OP_CLEAR: nxt = old & ~e.operand;
        default:               nxt = e.operand;
      endcase
      if (fault) begin // memory fault wins over everything.
        m_mepc   = pc;
        m_mcause = e.store ? 32'd15 : 32'd13;
        m_mtval  = e.vaddr;
      end else if (illegal) begin
        m_mepc   = pc;
        m_mcause = 32'd2;
        m_mtval  = {20'h0, e.addr};
      end else if (exp_rd) begin
        model_write(e.addr, nxt);
      end

      req.op       = e.op;
      req.addr     = e.addr;
      req.operand  = e.operand;
      req.pc       = pc;
      mreq.pc      = pc;
      mreq.vaddr   = e.vaddr;
      mreq.store   = e.store;
      @(posedge clk_i);
      csr_valid_i <= csr_act;
      csr_req_i   <= req;
      mem_valid_i <= mem_act;
      mem_req_i   <= mreq;
      @(posedge clk_i);
      csr_valid_i <= 1'b0;
      mem_valid_i <= 1'b0;

      errs_before = errors;
      waited      = 0;
      @(negedge clk_i);
      while (!(rd_valid_o || mem_ok_o || trap_o) && waited < TIMEOUT) begin
        @(negedge clk_i);
        waited++;
      end
      if (!(rd_valid_o || mem_ok_o || trap_o)) begin
        $display("test %0d: the DUT gave no response within %0d cycles", i, TIMEOUT);
        errors++;
      end else begin
        if (waited != 0) begin
          $display("test %0d: the DUT answered %0d cycles late", i, waited);
          errors++;
        end
        check_val("rd_valid_o", 32'(rd_valid_o), 32'(exp_rd));
        check_val("mem_ok_o", 32'(mem_ok_o), 32'(exp_ok));
        check_val("trap_o", 32'(trap_o), 32'(exp_trap));
        check_val("satp_o", satp_o, m_satp);
        if (exp_rd) begin
          check_val("rd_data_o", rd_data_o, old);
        end
        if (exp_trap) begin
          check_val("trap_pc_o", trap_pc_o, exp_pc);
        end
      end
      $display("test %0d kind %0d addr %h vaddr %h: %s", i, e.kind, e.addr, e.vaddr,
               (errors == errs_before) ? "ok" : "mismatch");
    end

    $display("%0d tests, %0d checks, %0d errors", tbl.size(), checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule : csr_tb

/* list.f */
rtl/csr_pkg.sv
rtl/mmu_pkg.sv
rtl/csr_regfile.sv
rtl/csr_op_unit.sv
rtl/page_check.sv
rtl/trap_ctrl.sv
rtl/csr_top.sv
dv/csr_tb.sv

/* rtl/csr_op_unit.sv */
module csr_op_unit (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               csr_valid_i,
  input  csr_pkg::csr_req_t                  csr_req_i,
  output logic [csr_pkg::CSR_ADDR_WIDTH-1:0] rd_addr_o,
  input  logic [csr_pkg::DATA_WIDTH-1:0]     rd_data_i,
  output logic                               csr_we_o,
  output logic [csr_pkg::CSR_ADDR_WIDTH-1:0] csr_waddr_o,
  output logic [csr_pkg::DATA_WIDTH-1:0]     csr_wdata_o,
  output logic                               illegal_o,
  output logic [csr_pkg::DATA_WIDTH-1:0]     illegal_pc_o,
  output logic [csr_pkg::CSR_ADDR_WIDTH-1:0] illegal_addr_o,
  output logic                               rd_valid_o,
  output logic [csr_pkg::DATA_WIDTH-1:0]     rd_data_o
);

  logic legal;

  always_comb begin
    case (csr_req_i.addr)
      csr_pkg::CSR_SATP,
      csr_pkg::CSR_MTVEC,
      csr_pkg::CSR_MEPC,
      csr_pkg::CSR_MCAUSE,
      csr_pkg::CSR_MTVAL,
      csr_pkg::CSR_PPN_SEL,
      csr_pkg::CSR_PPN_FLAG: legal = 1'b1;
      default:               legal = 1'b0;
    endcase
  end

  always_comb begin
    case (csr_req_i.op)
      csr_pkg::CSR_OP_SET:   csr_wdata_o = rd_data_i | csr_req_i.operand;
      csr_pkg::CSR_OP_CLEAR: csr_wdata_o = rd_data_i & ~csr_req_i.operand;
      default:               csr_wdata_o = csr_req_i.operand;
    endcase
  end

  assign rd_addr_o      = csr_req_i.addr; // old value is read every cycle.
  assign csr_waddr_o    = csr_req_i.addr;
  assign csr_we_o       = csr_valid_i && legal;
  assign illegal_o      = csr_valid_i && !legal;
  assign illegal_pc_o   = csr_req_i.pc;
  assign illegal_addr_o = csr_req_i.addr;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= csr_we_o;
    end
  end

  always_ff @(posedge clk_i) begin
    rd_data_o <= rd_data_i; // value before the update.
  end

  // a valid request carries one of the three operations.
  a_op_known : assert property (@(posedge clk_i) disable iff (!rst_i)
    csr_valid_i |-> (csr_req_i.op inside {csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_OP_SET,
                                          csr_pkg::CSR_OP_CLEAR}));

endmodule : csr_op_unit

/* rtl/csr_pkg.sv */
package csr_pkg;

  localparam int DATA_WIDTH     = 32;
  localparam int CSR_ADDR_WIDTH = 12;

  // machine-mode csr map.
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_SATP     = 12'h180;
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_MTVEC    = 12'h305;
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_MEPC     = 12'h341;
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_MCAUSE   = 12'h342;
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_MTVAL    = 12'h343;
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_PPN_SEL  = 12'h7C0; // custom page select.
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_PPN_FLAG = 12'h7C1; // custom flag in bit 0.

  typedef enum logic [1:0] {
    CSR_OP_WRITE = 2'b01, // csrrw.
    CSR_OP_SET   = 2'b10, // csrrs.
    CSR_OP_CLEAR = 2'b11  // csrrc.
  } csr_op_e;

  typedef struct packed {
    csr_op_e                   op;
    logic [CSR_ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0]     operand;
    logic [DATA_WIDTH-1:0]     pc;
  } csr_req_t;

  typedef struct packed {
    logic                  interrupt;
    logic [DATA_WIDTH-2:0] code;
  } excpt_cause_t;

  localparam logic [DATA_WIDTH-2:0] CAUSE_ILLEGAL  = 31'd2;
  localparam logic [DATA_WIDTH-2:0] CAUSE_LOAD_PF  = 31'd13;
  localparam logic [DATA_WIDTH-2:0] CAUSE_STORE_PF = 31'd15;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] mepc;
    excpt_cause_t          mcause;
    logic [DATA_WIDTH-1:0] mtval;
  } excpt_t;

endpackage : csr_pkg

/* rtl/csr_regfile.sv */
module csr_regfile (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               excpt_we_i,
  input  csr_pkg::excpt_t                    excpt_i,
  input  logic                               csr_we_i,
  input  logic [csr_pkg::CSR_ADDR_WIDTH-1:0] csr_waddr_i,
  input  logic [csr_pkg::DATA_WIDTH-1:0]     csr_wdata_i,
  input  logic [csr_pkg::CSR_ADDR_WIDTH-1:0] rd_addr_i,
  output logic [csr_pkg::DATA_WIDTH-1:0]     rd_data_o,
  input  logic                               present_req_i,
  input  logic [mmu_pkg::PPN_WIDTH-1:0]      present_ppn_i,
  output logic                               ppn_present_o,
  output logic [csr_pkg::DATA_WIDTH-1:0]     satp_o,
  output logic [csr_pkg::DATA_WIDTH-1:0]     mtvec_o
);

  logic [csr_pkg::DATA_WIDTH-1:0] satp;
  logic [csr_pkg::DATA_WIDTH-1:0] mtvec;
  logic [csr_pkg::DATA_WIDTH-1:0] mepc;
  logic [csr_pkg::DATA_WIDTH-1:0] mtval;
  csr_pkg::excpt_cause_t          mcause;
  logic [csr_pkg::DATA_WIDTH-1:0] ppn_sel; // software reads back the full value.
  logic [mmu_pkg::PPN_COUNT-1:0]  present;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      satp    <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mtval   <= '0;
      mcause  <= '0;
      ppn_sel <= '0;
      present <= '0;
    end else if (excpt_we_i) begin // trap record beats the csr write.
      mepc   <= excpt_i.mepc;
      mcause <= excpt_i.mcause;
      mtval  <= excpt_i.mtval;
    end else if (csr_we_i) begin
      case (csr_waddr_i)
        csr_pkg::CSR_SATP:     satp    <= csr_wdata_i;
        csr_pkg::CSR_MTVEC:    mtvec   <= csr_wdata_i;
        csr_pkg::CSR_MEPC:     mepc    <= csr_wdata_i;
        csr_pkg::CSR_MCAUSE:   mcause  <= csr_wdata_i;
        csr_pkg::CSR_MTVAL:    mtval   <= csr_wdata_i;
        csr_pkg::CSR_PPN_SEL:  ppn_sel <= csr_wdata_i;
        csr_pkg::CSR_PPN_FLAG: present[ppn_sel[mmu_pkg::PPN_WIDTH-1:0]] <= csr_wdata_i[0];
        default: ;
      endcase
    end
  end

  always_comb begin
    rd_data_o = '0; // flag csr reads as zero.
    case (rd_addr_i)
      csr_pkg::CSR_SATP:    rd_data_o = satp;
      csr_pkg::CSR_MTVEC:   rd_data_o = mtvec;
      csr_pkg::CSR_MEPC:    rd_data_o = mepc;
      csr_pkg::CSR_MCAUSE:  rd_data_o = mcause;
      csr_pkg::CSR_MTVAL:   rd_data_o = mtval;
      csr_pkg::CSR_PPN_SEL: rd_data_o = ppn_sel;
      default: ;
    endcase
  end

  always_comb begin
    ppn_present_o = 1'b0;
    if (present_req_i) begin
      ppn_present_o = present[present_ppn_i];
    end
  end

  assign satp_o  = satp;
  assign mtvec_o = mtvec;

  // software must pick a page inside the table before it sets a flag.
  a_sel_in_range : assert property (@(posedge clk_i) disable iff (!rst_i)
    (csr_we_i && !excpt_we_i && csr_waddr_i == csr_pkg::CSR_PPN_FLAG)
      |-> (ppn_sel < mmu_pkg::PPN_COUNT));

endmodule : csr_regfile

/* rtl/csr_top.sv */
module csr_top (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           csr_valid_i,
  input  csr_pkg::csr_req_t              csr_req_i,
  input  logic                           mem_valid_i,
  input  mmu_pkg::mem_req_t              mem_req_i,
  output logic                           rd_valid_o,
  output logic [csr_pkg::DATA_WIDTH-1:0] rd_data_o,
  output logic                           mem_ok_o,
  output logic                           trap_o,
  output logic [csr_pkg::DATA_WIDTH-1:0] trap_pc_o,
  output logic [csr_pkg::DATA_WIDTH-1:0] satp_o
);

  logic                               excpt_we;
  csr_pkg::excpt_t                    excpt;
  logic                               csr_we;
  logic [csr_pkg::CSR_ADDR_WIDTH-1:0] csr_waddr;
  logic [csr_pkg::DATA_WIDTH-1:0]     csr_wdata;
  logic [csr_pkg::CSR_ADDR_WIDTH-1:0] rd_addr;
  logic [csr_pkg::DATA_WIDTH-1:0]     rd_data;
  logic                               present_req;
  logic [mmu_pkg::PPN_WIDTH-1:0]      present_ppn;
  logic                               ppn_present;
  logic [csr_pkg::DATA_WIDTH-1:0]     mtvec;
  logic                               illegal;
  logic [csr_pkg::DATA_WIDTH-1:0]     illegal_pc;
  logic [csr_pkg::CSR_ADDR_WIDTH-1:0] illegal_addr;
  mmu_pkg::page_fault_t               fault;

  csr_regfile u_regfile (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .excpt_we_i    (excpt_we),
    .excpt_i       (excpt),
    .csr_we_i      (csr_we),
    .csr_waddr_i   (csr_waddr),
    .csr_wdata_i   (csr_wdata),
    .rd_addr_i     (rd_addr),
    .rd_data_o     (rd_data),
    .present_req_i (present_req),
    .present_ppn_i (present_ppn),
    .ppn_present_o (ppn_present),
    .satp_o        (satp_o),
    .mtvec_o       (mtvec)
  );

  csr_op_unit u_op_unit (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .csr_valid_i    (csr_valid_i),
    .csr_req_i      (csr_req_i),
    .rd_addr_o      (rd_addr),
    .rd_data_i      (rd_data),
    .csr_we_o       (csr_we),
    .csr_waddr_o    (csr_waddr),
    .csr_wdata_o    (csr_wdata),
    .illegal_o      (illegal),
    .illegal_pc_o   (illegal_pc),
    .illegal_addr_o (illegal_addr),
    .rd_valid_o     (rd_valid_o),
    .rd_data_o      (rd_data_o)
  );

  page_check u_page_check (
    .mem_valid_i   (mem_valid_i),
    .mem_req_i     (mem_req_i),
    .satp_i        (satp_o),
    .present_req_o (present_req),
    .present_ppn_o (present_ppn),
    .present_i     (ppn_present),
    .fault_o       (fault)
  );

  trap_ctrl u_trap_ctrl (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .mem_valid_i    (mem_valid_i),
    .fault_i        (fault),
    .illegal_i      (illegal),
    .illegal_pc_i   (illegal_pc),
    .illegal_addr_i (illegal_addr),
    .mtvec_i        (mtvec),
    .excpt_we_o     (excpt_we),
    .excpt_o        (excpt),
    .mem_ok_o       (mem_ok_o),
    .trap_o         (trap_o),
    .trap_pc_o      (trap_pc_o)
  );

endmodule : csr_top

/* rtl/mmu_pkg.sv */
package mmu_pkg;

  localparam int VADDR_WIDTH   = 32;
  localparam int PPN_WIDTH     = 8;
  localparam int PPN_COUNT     = 1 << PPN_WIDTH; // entries in the presence table.
  localparam int PAGE_SHIFT    = 12;
  localparam int SATP_MODE_BIT = 31;

  typedef struct packed {
    logic [VADDR_WIDTH-1:0] pc;
    logic [VADDR_WIDTH-1:0] vaddr;
    logic                   store;
  } mem_req_t;

  // result of the presence check for one access.
  typedef struct packed {
    logic                   fault;
    logic                   store;
    logic [VADDR_WIDTH-1:0] pc;
    logic [VADDR_WIDTH-1:0] vaddr;
  } page_fault_t;

endpackage : mmu_pkg

/* rtl/page_check.sv */
module page_check (
  input  logic                           mem_valid_i,
  input  mmu_pkg::mem_req_t              mem_req_i,
  input  logic [csr_pkg::DATA_WIDTH-1:0] satp_i,
  output logic                           present_req_o,
  output logic [mmu_pkg::PPN_WIDTH-1:0]  present_ppn_o,
  input  logic                           present_i,
  output mmu_pkg::page_fault_t           fault_o
);

  logic check_en;

  assign check_en = satp_i[mmu_pkg::SATP_MODE_BIT]; // bare mode when clear.

  // the identity map lets the vpn index the presence table directly.
  assign present_req_o = mem_valid_i && check_en;
  assign present_ppn_o = mem_req_i.vaddr[mmu_pkg::PAGE_SHIFT +: mmu_pkg::PPN_WIDTH];

  always_comb begin
    fault_o.fault = present_req_o && !present_i;
    fault_o.store = mem_req_i.store;
    fault_o.pc    = mem_req_i.pc;
    fault_o.vaddr = mem_req_i.vaddr;
  end

endmodule : page_check

/* rtl/trap_ctrl.sv */
module trap_ctrl (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               mem_valid_i,
  input  mmu_pkg::page_fault_t               fault_i,
  input  logic                               illegal_i,
  input  logic [csr_pkg::DATA_WIDTH-1:0]     illegal_pc_i,
  input  logic [csr_pkg::CSR_ADDR_WIDTH-1:0] illegal_addr_i,
  input  logic [csr_pkg::DATA_WIDTH-1:0]     mtvec_i,
  output logic                               excpt_we_o,
  output csr_pkg::excpt_t                    excpt_o,
  output logic                               mem_ok_o,
  output logic                               trap_o,
  output logic [csr_pkg::DATA_WIDTH-1:0]     trap_pc_o
);

  logic take_trap;

  assign take_trap  = fault_i.fault || illegal_i;
  assign excpt_we_o = take_trap;

  always_comb begin
    excpt_o.mcause.interrupt = 1'b0;
    if (fault_i.fault) begin // page fault wins over the csr trap.
      excpt_o.mepc        = fault_i.pc;
      excpt_o.mtval       = fault_i.vaddr;
      excpt_o.mcause.code = fault_i.store ? csr_pkg::CAUSE_STORE_PF : csr_pkg::CAUSE_LOAD_PF;
    end else begin
      excpt_o.mepc        = illegal_pc_i;
      excpt_o.mtval       = {{(csr_pkg::DATA_WIDTH - csr_pkg::CSR_ADDR_WIDTH){1'b0}},
                             illegal_addr_i};
      excpt_o.mcause.code = csr_pkg::CAUSE_ILLEGAL;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      trap_o   <= 1'b0;
      mem_ok_o <= 1'b0;
    end else begin
      trap_o   <= take_trap;
      mem_ok_o <= mem_valid_i && !take_trap; // a trap squashes the access.
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_trap) begin
      trap_pc_o <= mtvec_i;
    end
  end

  // a page fault only comes with a memory access.
  a_fault_with_access : assert property (@(posedge clk_i) disable iff (!rst_i)
    fault_i.fault |-> mem_valid_i);

endmodule : trap_ctrl

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f list.f --top-module csr_tb -o csr_tb_sim &&
./obj_dir/csr_tb_sim | tee /dev/stderr | grep -q "TB PASSED" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
